/* hdl/mmu_pkg.sv */
package mmu_pkg;

	// Address widths
	localparam int VADDR_W = 32;
	localparam int PADDR_W = 32;
	localparam int PAGE_W = 12;

	// Translation buffer size
	localparam int TLB_ENTRIES = 8;

	// Region table geometry
	localparam int REGIONS = 4;
	localparam int MODES = 4;
	// Top two address bits select the region
	localparam int REGION_SHIFT = 30;

	// Request queue between capture and check
	localparam int REQ_FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(REQ_FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(REQ_FIFO_DEPTH + 1);

	// Bit positions inside an rwx field
	localparam int RWX_W = 1;
	localparam int RWX_X = 0;

	typedef logic [VADDR_W-1:0] vaddr_t;
	typedef logic [PADDR_W-1:0] paddr_t;
	typedef logic [VADDR_W-PAGE_W-1:0] vpn_t;
	typedef logic [PADDR_W-PAGE_W-1:0] ppn_t;
	typedef logic [7:0] pl_t;
	// Read is bit 2, write bit 1, execute bit 0
	typedef logic [2:0] rwx_t;
	typedef logic [$clog2(TLB_ENTRIES)-1:0] tlb_idx_t;
	typedef logic [$clog2(REGIONS)-1:0] region_idx_t;

	// Value doubles as index into per-mode region attributes
	typedef enum logic [1:0] {
		OM_APP,
		OM_SUPERVISOR,
		OM_HYPERVISOR,
		OM_SECURE
	} op_mode_t;

	typedef enum logic [1:0] {
		RESP_OK,
		RESP_PRIV_FAULT,
		RESP_TLB_MISS
	} resp_code_t;

	typedef enum logic [1:0] {
		CS_IDLE,
		CS_LOOKUP,
		CS_RESP_HIGH,
		CS_RESP_LOW
	} check_state_t;

endpackage

/* hdl/mmu_req_capture.sv */
module mmu_req_capture import mmu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	// Four-phase request port
	input  logic     req,
	input  vaddr_t   req_vaddr,
	input  logic     req_id,
	input  logic     req_we,
	input  pl_t      req_cpl,
	input  op_mode_t req_om,
	output logic     ack,
	// Push side of the request buffer
	output logic     push,
	output vaddr_t   push_vaddr,
	output logic     push_id,
	output logic     push_we,
	output pl_t      push_cpl,
	output op_mode_t push_om,
	input  logic     full
);

	// Ack low means waiting for a new request
	// Ack high means waiting for req to drop
	// One push per handshake since push needs ack low
	assign push = req && !ack && !full;

	// Source holds the fields stable while req is high
	assign push_vaddr = req_vaddr;
	assign push_id = req_id;
	assign push_we = req_we;
	assign push_cpl = req_cpl;
	assign push_om = req_om;

	always_ff @(posedge clk)
	begin
		if (rst)
			ack <= 1'b0;
		else if (!ack)
		begin
			// Accept only with room in the buffer
			if (req && !full)
				ack <= 1'b1;
		end
		else if (!req)
		begin
			// Source finished its side of the handshake
			ack <= 1'b0;
		end
	end

endmodule

/* hdl/mmu_req_fifo.sv */
module mmu_req_fifo import mmu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  vaddr_t   push_vaddr,
	input  logic     push_id,
	input  logic     push_we,
	input  pl_t      push_cpl,
	input  op_mode_t push_om,
	output logic     full,
	input  logic     pop,
	output logic     empty,
	output vaddr_t   head_vaddr,
	output logic     head_id,
	output logic     head_we,
	output pl_t      head_cpl,
	output op_mode_t head_om
);

	// Storage for queued requests
	vaddr_t   vaddr_mem [REQ_FIFO_DEPTH];
	logic     id_mem [REQ_FIFO_DEPTH];
	logic     we_mem [REQ_FIFO_DEPTH];
	pl_t      cpl_mem [REQ_FIFO_DEPTH];
	op_mode_t om_mem [REQ_FIFO_DEPTH];

	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	// Wrap at the last slot
	function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
		if (ptr == FIFO_PTR_W'(REQ_FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full = (count == FIFO_CNT_W'(REQ_FIFO_DEPTH));
	assign empty = (count == '0);
	// Ignore push when full and pop when empty
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
		begin
			vaddr_mem[wr_ptr] <= push_vaddr;
			id_mem[wr_ptr] <= push_id;
			we_mem[wr_ptr] <= push_we;
			cpl_mem[wr_ptr] <= push_cpl;
			om_mem[wr_ptr] <= push_om;
		end
	end

	// Oldest entry
	assign head_vaddr = vaddr_mem[rd_ptr];
	assign head_id = id_mem[rd_ptr];
	assign head_we = we_mem[rd_ptr];
	assign head_cpl = cpl_mem[rd_ptr];
	assign head_om = om_mem[rd_ptr];

endmodule

/* hdl/mmu_tlb.sv */
module mmu_tlb import mmu_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	// Fill port, software names the slot
	input  logic     tlb_we,
	input  tlb_idx_t tlb_idx,
	input  vpn_t     tlb_vpn,
	input  ppn_t     tlb_ppn,
	input  pl_t      tlb_pl,
	input  logic     tlb_u,
	input  rwx_t     tlb_rwx,
	// Lookup
	input  vpn_t     lookup_vpn,
	output logic     hit,
	output ppn_t     hit_ppn,
	output pl_t      hit_pl,
	output logic     hit_u,
	output rwx_t     hit_rwx
);

	logic valid [TLB_ENTRIES];
	vpn_t tag [TLB_ENTRIES];
	// PTE fields
	ppn_t ppn [TLB_ENTRIES];
	pl_t  pl [TLB_ENTRIES];
	logic u [TLB_ENTRIES];
	rwx_t rwx [TLB_ENTRIES];

	// Reset invalidates every slot
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < TLB_ENTRIES; i++)
				valid[i] <= 1'b0;
		end
		else if (tlb_we)
			valid[tlb_idx] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (tlb_we)
		begin
			tag[tlb_idx] <= tlb_vpn;
			ppn[tlb_idx] <= tlb_ppn;
			pl[tlb_idx] <= tlb_pl;
			u[tlb_idx] <= tlb_u;
			rwx[tlb_idx] <= tlb_rwx;
		end
	end

	// Parallel tag compare
	// Scan downward so the lowest matching slot is the last one written
	always_comb
	begin
		hit = 1'b0;
		hit_ppn = '0;
		hit_pl = '0;
		hit_u = 1'b0;
		hit_rwx = '0;
		for (int i = TLB_ENTRIES - 1; i >= 0; i--)
		begin
			if (valid[i] && tag[i] == lookup_vpn)
			begin
				hit = 1'b1;
				hit_ppn = ppn[i];
				hit_pl = pl[i];
				hit_u = u[i];
				hit_rwx = rwx[i];
			end
		end
	end

endmodule

/* hdl/mmu_region_table.sv */
module mmu_region_table import mmu_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	// Configuration write
	input  logic                   rgn_we,
	input  region_idx_t            rgn_idx,
	input  op_mode_t               rgn_mode,
	input  rwx_t                   rgn_rwx,
	// Lookup by region number
	input  region_idx_t            lookup_region,
	output rwx_t [MODES-1:0]       region_rwx
);

	// One attribute set per region and mode
	rwx_t attr [REGIONS][MODES];

	// Cleared table leaves every write bit off
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int r = 0; r < REGIONS; r++)
			begin
				for (int m = 0; m < MODES; m++)
					attr[r][m] <= '0;
			end
		end
		else if (rgn_we)
			attr[rgn_idx][rgn_mode] <= rgn_rwx;
	end

	// All modes of the selected region
	always_comb
	begin
		for (int m = 0; m < MODES; m++)
			region_rwx[m] = attr[lookup_region][m];
	end

endmodule

/* hdl/mmu_attr_check.sv */
module mmu_attr_check import mmu_pkg::*; (
	// Instruction fetch when high
	input  logic             id,
	input  pl_t              cpl,
	input  op_mode_t         om,
	input  logic             we,
	// Fields of the matching PTE
	input  pl_t              pte_pl,
	input  logic             pte_u,
	input  rwx_t             pte_rwx,
	// Region attributes for every mode
	input  rwx_t [MODES-1:0] region_rwx,
	output logic             priv_err
);

	rwx_t rgn;
	logic lvl_err;
	logic fetch_we_err;
	logic rgn_ro_err;
	logic rgn_x_err;
	logic user_err;
	logic pte_ro_err;
	logic pte_x_err;

	// Mode value picks its own region attribute
	assign rgn = region_rwx[om];

	// Data needs cpl at or above pl
	// Fetch needs cpl below pl
	assign lvl_err = id ? (cpl >= pte_pl) : (cpl < pte_pl);
	// Fetch combined with a write
	assign fetch_we_err = id && we;
	// Writes to a read-only region
	assign rgn_ro_err = we && !rgn[RWX_W];
	// Data access into an executable region
	assign rgn_x_err = !id && rgn[RWX_X];
	// Page not marked for user
	assign user_err = !pte_u;
	// Writes to a read-only page
	assign pte_ro_err = we && !pte_rwx[RWX_W];
	// Data access into an executable page
	assign pte_x_err = !id && pte_rwx[RWX_X];

	always_comb
	begin
		priv_err = 1'b0;
		case (om)
			OM_APP:
				priv_err = lvl_err || fetch_we_err || rgn_ro_err || rgn_x_err ||
					user_err || pte_ro_err || pte_x_err;
			// Same as app except user pages are not required
			OM_SUPERVISOR:
				priv_err = lvl_err || fetch_we_err || rgn_ro_err || rgn_x_err ||
					pte_ro_err || pte_x_err;
			// TLB attributes and levels are ignored here
			OM_HYPERVISOR:
				priv_err = fetch_we_err || rgn_ro_err;
			OM_SECURE:
				priv_err = rgn_ro_err;
			default:
				priv_err = 1'b0;
		endcase
	end

endmodule

/* hdl/mmu_check_stage.sv */
module mmu_check_stage import mmu_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	// Request buffer head
	input  logic        empty,
	input  vaddr_t      head_vaddr,
	input  logic        head_id,
	input  logic        head_we,
	input  pl_t         head_cpl,
	input  op_mode_t    head_om,
	output logic        pop,
	// TLB fill
	input  logic        tlb_we,
	input  tlb_idx_t    tlb_idx,
	input  vpn_t        tlb_vpn,
	input  ppn_t        tlb_ppn,
	input  pl_t         tlb_pl,
	input  logic        tlb_u,
	input  rwx_t        tlb_rwx,
	// Region write
	input  logic        rgn_we,
	input  region_idx_t rgn_idx,
	input  op_mode_t    rgn_mode,
	input  rwx_t        rgn_rwx,
	// Four-phase response port
	output logic        resp_req,
	output paddr_t      resp_paddr,
	output resp_code_t  resp_code,
	input  logic        resp_ack
);

	check_state_t state;
	// Request taken from the buffer
	vaddr_t   cur_vaddr;
	logic     cur_id;
	logic     cur_we;
	pl_t      cur_cpl;
	op_mode_t cur_om;
	logic hit;
	ppn_t hit_ppn;
	pl_t  hit_pl;
	logic hit_u;
	rwx_t hit_rwx;
	rwx_t [MODES-1:0] region_rwx;
	logic priv_err;

	mmu_tlb tlb_inst (
		.clk        (clk),
		.rst        (rst),
		.tlb_we     (tlb_we),
		.tlb_idx    (tlb_idx),
		.tlb_vpn    (tlb_vpn),
		.tlb_ppn    (tlb_ppn),
		.tlb_pl     (tlb_pl),
		.tlb_u      (tlb_u),
		.tlb_rwx    (tlb_rwx),
		.lookup_vpn (cur_vaddr[VADDR_W-1:PAGE_W]),
		.hit        (hit),
		.hit_ppn    (hit_ppn),
		.hit_pl     (hit_pl),
		.hit_u      (hit_u),
		.hit_rwx    (hit_rwx)
	);

	mmu_region_table region_table_inst (
		.clk           (clk),
		.rst           (rst),
		.rgn_we        (rgn_we),
		.rgn_idx       (rgn_idx),
		.rgn_mode      (rgn_mode),
		.rgn_rwx       (rgn_rwx),
		.lookup_region (cur_vaddr[REGION_SHIFT +: $bits(region_idx_t)]),
		.region_rwx    (region_rwx)
	);

	mmu_attr_check attr_check_inst (
		.id         (cur_id),
		.cpl        (cur_cpl),
		.om         (cur_om),
		.we         (cur_we),
		.pte_pl     (hit_pl),
		.pte_u      (hit_u),
		.pte_rwx    (hit_rwx),
		.region_rwx (region_rwx),
		.priv_err   (priv_err)
	);

	// Take one request whenever idle
	assign pop = (state == CS_IDLE) && !empty;
	assign resp_req = (state == CS_RESP_HIGH);

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= CS_IDLE;
		else
		begin
			case (state)
				CS_IDLE:
					if (!empty)
						state <= CS_LOOKUP;
				CS_LOOKUP:
					state <= CS_RESP_HIGH;
				// Hold the response until the consumer takes it
				CS_RESP_HIGH:
					if (resp_ack)
						state <= CS_RESP_LOW;
				CS_RESP_LOW:
					if (!resp_ack)
						state <= CS_IDLE;
				default:
					state <= CS_IDLE;
			endcase
		end
	end

	// Payload registers
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			cur_vaddr <= head_vaddr;
			cur_id <= head_id;
			cur_we <= head_we;
			cur_cpl <= head_cpl;
			cur_om <= head_om;
		end
		// Results stay put through the whole handshake
		if (state == CS_LOOKUP)
		begin
			if (!hit)
			begin
				// No translation for a miss
				resp_paddr <= '0;
				resp_code <= RESP_TLB_MISS;
			end
			else
			begin
				resp_paddr <= {hit_ppn, cur_vaddr[PAGE_W-1:0]};
				resp_code <= priv_err ? RESP_PRIV_FAULT : RESP_OK;
			end
		end
	end

endmodule

/* hdl/mmu_access_unit.sv */
module mmu_access_unit import mmu_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	// Request port
	input  logic        req,
	input  vaddr_t      req_vaddr,
	input  logic        req_id,
	input  logic        req_we,
	input  pl_t         req_cpl,
	input  op_mode_t    req_om,
	output logic        ack,
	// Response port
	output logic        resp_req,
	output paddr_t      resp_paddr,
	output resp_code_t  resp_code,
	input  logic        resp_ack,
	// TLB fill
	input  logic        tlb_we,
	input  tlb_idx_t    tlb_idx,
	input  vpn_t        tlb_vpn,
	input  ppn_t        tlb_ppn,
	input  pl_t         tlb_pl,
	input  logic        tlb_u,
	input  rwx_t        tlb_rwx,
	// Region write
	input  logic        rgn_we,
	input  region_idx_t rgn_idx,
	input  op_mode_t    rgn_mode,
	input  rwx_t        rgn_rwx
);

	// Capture to buffer
	logic     push;
	vaddr_t   push_vaddr;
	logic     push_id;
	logic     push_we;
	pl_t      push_cpl;
	op_mode_t push_om;
	logic     full;
	// Buffer to check stage
	logic     pop;
	logic     empty;
	vaddr_t   head_vaddr;
	logic     head_id;
	logic     head_we;
	pl_t      head_cpl;
	op_mode_t head_om;

	mmu_req_capture req_capture_inst (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.req_vaddr  (req_vaddr),
		.req_id     (req_id),
		.req_we     (req_we),
		.req_cpl    (req_cpl),
		.req_om     (req_om),
		.ack        (ack),
		.push       (push),
		.push_vaddr (push_vaddr),
		.push_id    (push_id),
		.push_we    (push_we),
		.push_cpl   (push_cpl),
		.push_om    (push_om),
		.full       (full)
	);

	mmu_req_fifo req_fifo_inst (
		.clk        (clk),
		.rst        (rst),
		.push       (push),
		.push_vaddr (push_vaddr),
		.push_id    (push_id),
		.push_we    (push_we),
		.push_cpl   (push_cpl),
		.push_om    (push_om),
		.full       (full),
		.pop        (pop),
		.empty      (empty),
		.head_vaddr (head_vaddr),
		.head_id    (head_id),
		.head_we    (head_we),
		.head_cpl   (head_cpl),
		.head_om    (head_om)
	);

	mmu_check_stage check_stage_inst (
		.clk        (clk),
		.rst        (rst),
		.empty      (empty),
		.head_vaddr (head_vaddr),
		.head_id    (head_id),
		.head_we    (head_we),
		.head_cpl   (head_cpl),
		.head_om    (head_om),
		.pop        (pop),
		.tlb_we     (tlb_we),
		.tlb_idx    (tlb_idx),
		.tlb_vpn    (tlb_vpn),
		.tlb_ppn    (tlb_ppn),
		.tlb_pl     (tlb_pl),
		.tlb_u      (tlb_u),
		.tlb_rwx    (tlb_rwx),
		.rgn_we     (rgn_we),
		.rgn_idx    (rgn_idx),
		.rgn_mode   (rgn_mode),
		.rgn_rwx    (rgn_rwx),
		.resp_req   (resp_req),
		.resp_paddr (resp_paddr),
		.resp_code  (resp_code),
		.resp_ack   (resp_ack)
	);

endmodule

/* verification/mmu_access_unit_checker.sv */
module mmu_access_unit_checker import mmu_pkg::*; (
	input logic       clk,
	input logic       rst,
	input logic       req,
	input logic       ack,
	input logic       resp_req,
	input logic       resp_ack,
	input paddr_t     resp_paddr,
	input resp_code_t resp_code
);

	timeunit 1ns;
	timeprecision 100ps;

	// Count of failed assertions
	int fail_count = 0;

	// Both handshake outputs start low
	reset_outputs_low: assert property (@(posedge clk) rst |=> !ack && !resp_req)
	else
	begin
		fail_count++;
		$error("ack or resp_req high after reset");
	end

	// Ack only answers a pending req
	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> $past(req))
	else
	begin
		fail_count++;
		$error("ack rose without req");
	end

	// Response held until taken
	resp_held: assert property (@(posedge clk) disable iff (rst)
		resp_req && !resp_ack |=> resp_req)
	else
	begin
		fail_count++;
		$error("resp_req dropped before resp_ack");
	end

	// Payload frozen during the handshake
	payload_stable: assert property (@(posedge clk) disable iff (rst)
		resp_req && $past(resp_req) |-> $stable(resp_paddr) && $stable(resp_code))
	else
	begin
		fail_count++;
		$error("response payload changed while resp_req was high");
	end

endmodule

bind mmu_access_unit mmu_access_unit_checker checker_inst (
	.clk        (clk),
	.rst        (rst),
	.req        (req),
	.ack        (ack),
	.resp_req   (resp_req),
	.resp_ack   (resp_ack),
	.resp_paddr (resp_paddr),
	.resp_code  (resp_code)
);

/* verification/mmu_access_unit_tb.sv */
module mmu_access_unit_tb import mmu_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic        clk;
	logic        rst;
	logic        req;
	vaddr_t      req_vaddr;
	logic        req_id;
	logic        req_we;
	pl_t         req_cpl;
	op_mode_t    req_om;
	logic        ack;
	logic        resp_req;
	paddr_t      resp_paddr;
	resp_code_t  resp_code;
	logic        resp_ack;
	logic        tlb_we;
	tlb_idx_t    tlb_idx;
	vpn_t        tlb_vpn;
	ppn_t        tlb_ppn;
	pl_t         tlb_pl;
	logic        tlb_u;
	rwx_t        tlb_rwx;
	logic        rgn_we;
	region_idx_t rgn_idx;
	op_mode_t    rgn_mode;
	rwx_t        rgn_rwx;

	// Reference copy of the TLB and region table
	logic m_valid [TLB_ENTRIES];
	vpn_t m_tag [TLB_ENTRIES];
	ppn_t m_ppn [TLB_ENTRIES];
	pl_t  m_pl [TLB_ENTRIES];
	logic m_u [TLB_ENTRIES];
	rwx_t m_rwx [TLB_ENTRIES];
	rwx_t m_rgn [REGIONS][MODES];

	// Expected responses in issue order
	paddr_t     exp_paddr_q[$];
	resp_code_t exp_code_q[$];
	logic       exp_hit_q[$];

	int seed = 32'h786d_2c54;
	// 60 requests at 40 cycles each
	int cycle_limit = 60 * 40;
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int responses = 0;
	int total;
	logic hold_resp;
	logic batch_done;

	mmu_access_unit mmu_access_unit_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout after %0d cycles with %0d responses outstanding",
				cycles, exp_code_q.size());
			$display("Simulation FAILED");
			$finish;
		end
	end

	// Expected code and address from the access rules
	function automatic resp_code_t predict_code(input vaddr_t va, input logic id,
		input logic we, input pl_t cpl, input op_mode_t om, output paddr_t pa,
		output logic hit);
		int slot;
		rwx_t rgn;
		logic data;
		logic fault;
		slot = -1;
		// Lowest matching slot wins
		for (int i = 0; i < TLB_ENTRIES && slot < 0; i++)
		begin
			if (m_valid[i] && m_tag[i] == va[VADDR_W-1:PAGE_W])
				slot = i;
		end
		hit = (slot >= 0);
		pa = '0;
		if (!hit)
			return RESP_TLB_MISS;
		pa = {m_ppn[slot], va[PAGE_W-1:0]};
		rgn = m_rgn[va[VADDR_W-1:REGION_SHIFT]][om];
		data = !id;
		case (om)
			OM_APP, OM_SUPERVISOR:
				fault = (data && cpl < m_pl[slot]) || (id && cpl >= m_pl[slot])
					|| (id && we) || (we && !rgn[1]) || (data && rgn[0])
					|| (om == OM_APP && !m_u[slot])
					|| (we && !m_rwx[slot][1]) || (data && m_rwx[slot][0]);
			OM_HYPERVISOR:
				fault = (id && we) || (we && !rgn[1]);
			default:
				fault = we && !rgn[1];
		endcase
		return fault ? RESP_PRIV_FAULT : RESP_OK;
	endfunction

	task automatic fill_tlb(input tlb_idx_t idx, input vpn_t vpn, input ppn_t ppn,
		input pl_t pl, input logic u, input rwx_t rwx);
		@(negedge clk);
		tlb_we = 1'b1;
		tlb_idx = idx;
		tlb_vpn = vpn;
		tlb_ppn = ppn;
		tlb_pl = pl;
		tlb_u = u;
		tlb_rwx = rwx;
		@(negedge clk);
		tlb_we = 1'b0;
		m_valid[idx] = 1'b1;
		m_tag[idx] = vpn;
		m_ppn[idx] = ppn;
		m_pl[idx] = pl;
		m_u[idx] = u;
		m_rwx[idx] = rwx;
	endtask

	task automatic write_region(input region_idx_t idx, input op_mode_t mode, input rwx_t rwx);
		@(negedge clk);
		rgn_we = 1'b1;
		rgn_idx = idx;
		rgn_mode = mode;
		rgn_rwx = rwx;
		@(negedge clk);
		rgn_we = 1'b0;
		m_rgn[idx][mode] = rwx;
	endtask

	// Full four-phase exchange on the request port
	task automatic send_request(input vaddr_t va, input logic id, input logic we,
		input pl_t cpl, input op_mode_t om);
		paddr_t pa;
		logic hit;
		resp_code_t code;
		code = predict_code(va, id, we, cpl, om, pa, hit);
		exp_code_q.push_back(code);
		exp_paddr_q.push_back(pa);
		exp_hit_q.push_back(hit);
		@(negedge clk);
		req_vaddr = va;
		req_id = id;
		req_we = we;
		req_cpl = cpl;
		req_om = om;
		req = 1'b1;
		do
			@(negedge clk);
		while (!ack);
		req = 1'b0;
		do
			@(negedge clk);
		while (ack);
	endtask

	task automatic check_response();
		resp_code_t code;
		paddr_t pa;
		logic hit;
		responses++;
		if (exp_code_q.size() == 0)
		begin
			$display("Response arrived with no request outstanding");
			errors++;
			return;
		end
		code = exp_code_q.pop_front();
		pa = exp_paddr_q.pop_front();
		hit = exp_hit_q.pop_front();
		checks++;
		assert (resp_code === code)
		else
		begin
			$display("CHECK FAILED resp_code got %h expected %h", resp_code, code);
			errors++;
		end
		// Address only means something on a hit
		if (hit)
		begin
			checks++;
			assert (resp_paddr === pa)
			else
			begin
				$display("CHECK FAILED resp_paddr got %h expected %h", resp_paddr, pa);
				errors++;
			end
		end
	endtask

	task automatic wait_drain();
		while (exp_code_q.size() != 0 || resp_req || resp_ack)
			@(negedge clk);
	endtask

	// Mixed OK and fault traffic plus one miss
	task automatic issue_batch();
		for (int i = 0; i < 7; i++)
		begin
			if (i == 3)
				send_request(32'h0005_0000, 1'b0, 1'b0, 8'd5, OM_APP);
			else if (i % 2 == 0)
				send_request(32'h0001_0000 + 32'(i * 16), 1'b0, 1'b0, 8'd5, OM_APP);
			else
				send_request(32'h0001_2000 + 32'(i * 16), 1'b0, 1'b1, 8'd5, OM_APP);
		end
		batch_done = 1'b1;
	endtask

	// Consumer side, sometimes slow
	initial
	begin : responder
		int delay;
		resp_ack = 1'b0;
		forever
		begin
			@(negedge clk);
			if (resp_req && !resp_ack && !hold_resp)
			begin
				check_response();
				delay = $unsigned($random(seed)) % 4;
				repeat (delay)
					@(negedge clk);
				resp_ack = 1'b1;
				do
					@(negedge clk);
				while (resp_req);
				resp_ack = 1'b0;
			end
		end
	end

	initial
	begin
		rst = 1'b1;
		req = 1'b0;
		req_vaddr = '0;
		req_id = 1'b0;
		req_we = 1'b0;
		req_cpl = '0;
		req_om = OM_APP;
		tlb_we = 1'b0;
		tlb_idx = '0;
		tlb_vpn = '0;
		tlb_ppn = '0;
		tlb_pl = '0;
		tlb_u = 1'b0;
		tlb_rwx = '0;
		rgn_we = 1'b0;
		rgn_idx = '0;
		rgn_mode = OM_APP;
		rgn_rwx = '0;
		hold_resp = 1'b0;
		batch_done = 1'b0;
		for (int i = 0; i < TLB_ENTRIES; i++)
			m_valid[i] = 1'b0;
		for (int r = 0; r < REGIONS; r++)
		begin
			for (int m = 0; m < MODES; m++)
				m_rgn[r][m] = '0;
		end
		repeat (2)
			@(negedge clk);
		rst = 1'b0;

		// Quiet response port until a request comes in
		repeat (10)
		begin
			@(negedge clk);
			checks++;
			assert (!resp_req)
			else
			begin
				$display("CHECK FAILED resp_req got %h expected 0", resp_req);
				errors++;
			end
		end

		// Empty TLB misses in every mode
		for (int m = 0; m < MODES; m++)
			send_request(32'h0000_5000, 1'b0, 1'b0, 8'd3, op_mode_t'(m));
		wait_drain();

		// Region 0 rw, region 1 read only, region 2 read and execute
		for (int m = 0; m < MODES; m++)
		begin
			write_region(2'd0, op_mode_t'(m), 3'b110);
			write_region(2'd1, op_mode_t'(m), 3'b100);
			write_region(2'd2, op_mode_t'(m), 3'b101);
		end
		fill_tlb(3'd0, 20'h00010, 20'h12345, 8'd4, 1'b1, 3'b110);
		// Supervisor page
		fill_tlb(3'd1, 20'h00011, 20'h0abcd, 8'd4, 1'b0, 3'b110);
		// Read-only page
		fill_tlb(3'd2, 20'h00012, 20'h00777, 8'd4, 1'b1, 3'b100);
		// Executable page
		fill_tlb(3'd3, 20'h00013, 20'h00888, 8'd4, 1'b1, 3'b111);
		fill_tlb(3'd4, 20'h40020, 20'h00999, 8'd4, 1'b1, 3'b110);
		fill_tlb(3'd5, 20'h80030, 20'h00aaa, 8'd4, 1'b1, 3'b110);
		// Same tag twice, slot 6 must win
		fill_tlb(3'd7, 20'h00014, 20'h00007, 8'd4, 1'b1, 3'b110);
		fill_tlb(3'd6, 20'h00014, 20'h00006, 8'd4, 1'b1, 3'b110);

		// App mode, clean accesses then one fault rule at a time
		send_request(32'h0001_0abc, 1'b0, 1'b0, 8'd5, OM_APP);
		send_request(32'h0001_0ffc, 1'b0, 1'b1, 8'd4, OM_APP);
		send_request(32'h0001_0004, 1'b1, 1'b0, 8'd2, OM_APP);
		send_request(32'h0001_4008, 1'b0, 1'b0, 8'd5, OM_APP);
		send_request(32'h0001_0010, 1'b0, 1'b0, 8'd3, OM_APP);
		send_request(32'h0001_0020, 1'b1, 1'b0, 8'd4, OM_APP);
		send_request(32'h0001_0030, 1'b1, 1'b1, 8'd2, OM_APP);
		send_request(32'h4002_0010, 1'b0, 1'b1, 8'd5, OM_APP);
		send_request(32'h8003_0010, 1'b0, 1'b0, 8'd5, OM_APP);
		send_request(32'h0001_1000, 1'b0, 1'b0, 8'd5, OM_APP);
		send_request(32'h0001_2000, 1'b0, 1'b1, 8'd5, OM_APP);
		send_request(32'h0001_3000, 1'b0, 1'b0, 8'd5, OM_APP);
		wait_drain();

		// Supervisor ignores only the user bit
		send_request(32'h0001_1040, 1'b0, 1'b0, 8'd5, OM_SUPERVISOR);
		send_request(32'h0001_1080, 1'b0, 1'b0, 8'd3, OM_SUPERVISOR);
		send_request(32'h0001_2040, 1'b0, 1'b1, 8'd5, OM_SUPERVISOR);
		send_request(32'h4002_0040, 1'b0, 1'b1, 8'd5, OM_SUPERVISOR);
		wait_drain();

		// Hypervisor, page level and attributes are ignored
		send_request(32'h0001_0100, 1'b0, 1'b0, 8'd3, OM_HYPERVISOR);
		send_request(32'h0001_2100, 1'b0, 1'b1, 8'd5, OM_HYPERVISOR);
		send_request(32'h0001_1100, 1'b0, 1'b0, 8'd5, OM_HYPERVISOR);
		send_request(32'h0001_3100, 1'b0, 1'b0, 8'd5, OM_HYPERVISOR);
		send_request(32'h0001_0200, 1'b1, 1'b1, 8'd2, OM_HYPERVISOR);
		send_request(32'h4002_0100, 1'b0, 1'b1, 8'd5, OM_HYPERVISOR);
		send_request(32'h8003_0100, 1'b0, 1'b0, 8'd5, OM_HYPERVISOR);
		// Secure checks the region write bit only
		send_request(32'h0001_0300, 1'b0, 1'b0, 8'd3, OM_SECURE);
		send_request(32'h0001_0400, 1'b1, 1'b1, 8'd2, OM_SECURE);
		send_request(32'h4002_0200, 1'b0, 1'b1, 8'd5, OM_SECURE);
		send_request(32'h8003_0200, 1'b0, 1'b0, 8'd5, OM_SECURE);
		// User bit clear, read-only page write, executable page
		send_request(32'h0001_1200, 1'b0, 1'b0, 8'd5, OM_SECURE);
		send_request(32'h0001_2200, 1'b0, 1'b1, 8'd5, OM_SECURE);
		send_request(32'h0001_3200, 1'b0, 1'b0, 8'd5, OM_SECURE);
		wait_drain();

		// Withheld resp_ack backs up into the buffer
		hold_resp = 1'b1;
		fork
			issue_batch();
		join_none
		repeat (30)
			@(negedge clk);
		checks++;
		assert (req && !ack)
		else
		begin
			$display("Request was accepted although the buffer should be full");
			errors++;
		end
		hold_resp = 1'b0;
		wait (batch_done);
		wait_drain();
		repeat (5)
			@(negedge clk);

		total = errors + mmu_access_unit_inst.checker_inst.fail_count;
		$display("Summary: %0d responses, %0d checks, %0d errors, %0d assertion failures",
			responses, checks, errors, mmu_access_unit_inst.checker_inst.fail_count);
		if (total == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* build.f */
hdl/mmu_pkg.sv
hdl/mmu_req_capture.sv
hdl/mmu_req_fifo.sv
hdl/mmu_tlb.sv
hdl/mmu_region_table.sv
hdl/mmu_attr_check.sv
hdl/mmu_check_stage.sv
hdl/mmu_access_unit.sv
verification/mmu_access_unit_checker.sv
verification/mmu_access_unit_tb.sv

/* Bender.yml */
package:
  name: mmu_access_unit

sources:
  - hdl/mmu_pkg.sv
  - hdl/mmu_req_capture.sv
  - hdl/mmu_req_fifo.sv
  - hdl/mmu_tlb.sv
  - hdl/mmu_region_table.sv
  - hdl/mmu_attr_check.sv
  - hdl/mmu_check_stage.sv
  - hdl/mmu_access_unit.sv
  - target: test
    files:
      - verification/mmu_access_unit_checker.sv
      - verification/mmu_access_unit_tb.sv
